// ==== filelist.f ====
src/zap_pkg.sv
src/zap_irq_sync.sv
src/zap_wb_merger.sv
src/zap_store_buffer.sv
src/zap_mem_top.sv
verification/tb_clk_gen.sv
verification/tb_zap_mem_top.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
        --top-module tb_zap_mem_top \
        -f filelist.f \
        -o sim_tb
status=$?
if [ $status -ne 0 ]; then
        echo "Verilator build failed."
        exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
        echo "Simulation ended with status $status."
        exit $status
fi

exit 0

// ==== src/zap_irq_sync.sv ====
// ----------------------------------------
// Interrupt synchronizer.
// Brings the level triggered IRQ and FIQ
// lines into the clock domain through two
// flop ranks each.
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module zap_irq_sync
(
        input   logic   i_clk,
        input   logic   i_rst_n,
        input   logic   i_irq,
        input   logic   i_fiq,
        output  logic   o_irq,
        output  logic   o_fiq
);

logic irq_meta;                         // First rank.
logic fiq_meta;

always_ff @(posedge i_clk or negedge i_rst_n)
begin
        if (!i_rst_n)
        begin
                irq_meta <= 1'b0;
                fiq_meta <= 1'b0;
                o_irq    <= 1'b0;
                o_fiq    <= 1'b0;
        end
        else
        begin
                irq_meta <= i_irq;
                fiq_meta <= i_fiq;
                o_irq    <= irq_meta;   // Second rank.
                o_fiq    <= fiq_meta;
        end
end

endmodule

`default_nettype wire

// ==== src/zap_mem_top.sv ====
// ----------------------------------------
// ZAP memory side front end.
// Synchronizes the interrupt lines and
// merges the fetch and data ports onto one
// Wishbone master behind a store buffer.
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module zap_mem_top
(
        input   logic                   i_clk,
        input   logic                   i_rst_n,

        // Level triggered interrupts.
        input   logic                   i_irq,
        input   logic                   i_fiq,
        output  logic                   o_irq,
        output  logic                   o_fiq,

        // ----------------------------------------
        // Instruction port
        // ----------------------------------------

        input   logic                   i_instr_stb,
        input   zap_pkg::zap_addr_t     i_instr_adr,
        output  logic                   o_instr_ack,
        output  zap_pkg::zap_data_t     o_instr_dat,

        // ----------------------------------------
        // Data port
        // ----------------------------------------

        input   logic                   i_data_stb,
        input   logic                   i_data_we,
        input   zap_pkg::zap_addr_t     i_data_adr,
        input   zap_pkg::zap_sel_t      i_data_sel,
        input   zap_pkg::zap_data_t     i_data_dat,
        output  logic                   o_data_ack,
        output  zap_pkg::zap_data_t     o_data_dat,

        // ----------------------------------------
        // External Wishbone bus
        // ----------------------------------------

        output  logic                   o_wb_cyc,
        output  logic                   o_wb_stb,
        output  logic                   o_wb_we,
        output  zap_pkg::zap_addr_t     o_wb_adr,
        output  zap_pkg::zap_sel_t      o_wb_sel,
        output  zap_pkg::zap_data_t     o_wb_dat,
        input   logic                   i_wb_ack,
        input   zap_pkg::zap_data_t     i_wb_dat
);

// Merged request into the store buffer.
logic                   mrg_stb;
logic                   mrg_we;
zap_pkg::zap_addr_t     mrg_adr;
zap_pkg::zap_sel_t      mrg_sel;
zap_pkg::zap_data_t     mrg_dat;
logic                   sb_ack;
zap_pkg::zap_data_t     sb_dat;

zap_irq_sync u_irq_sync
(
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_irq          (i_irq),
        .i_fiq          (i_fiq),
        .o_irq          (o_irq),
        .o_fiq          (o_fiq)
);

zap_wb_merger u_wb_merger
(
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_c_stb        (i_instr_stb),
        .i_c_adr        (i_instr_adr),
        .o_c_ack        (o_instr_ack),
        .i_d_stb        (i_data_stb),
        .i_d_we         (i_data_we),
        .i_d_adr        (i_data_adr),
        .i_d_sel        (i_data_sel),
        .i_d_dat        (i_data_dat),
        .o_d_ack        (o_data_ack),
        .o_stb          (mrg_stb),
        .o_we           (mrg_we),
        .o_adr          (mrg_adr),
        .o_sel          (mrg_sel),
        .o_dat          (mrg_dat),
        .i_ack          (sb_ack)
);

zap_store_buffer u_store_buffer
(
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_stb          (mrg_stb),
        .i_we           (mrg_we),
        .i_adr          (mrg_adr),
        .i_sel          (mrg_sel),
        .i_dat          (mrg_dat),
        .o_ack          (sb_ack),
        .o_dat          (sb_dat),
        .o_wb_cyc       (o_wb_cyc),
        .o_wb_stb       (o_wb_stb),
        .o_wb_we        (o_wb_we),
        .o_wb_adr       (o_wb_adr),
        .o_wb_sel       (o_wb_sel),
        .o_wb_dat       (o_wb_dat),
        .i_wb_ack       (i_wb_ack),
        .i_wb_dat       (i_wb_dat)
);

// Read data is shared; the acks tell the owner.
assign o_instr_dat = sb_dat;
assign o_data_dat  = sb_dat;

endmodule

`default_nettype wire

// ==== src/zap_pkg.sv ====
// ----------------------------------------
// ZAP memory front end shared definitions.
// Bus widths, store buffer sizing and the
// types used across the front end blocks.
// ----------------------------------------

`default_nettype none

package zap_pkg;

        // ----------------------------------------
        // Bus geometry
        // ----------------------------------------

        localparam int ZAP_ADDR_W = 32;         // Byte address.
        localparam int ZAP_DATA_W = 32;         // One word.
        localparam int ZAP_SEL_W  = 4;          // Byte lanes per word.

        // ----------------------------------------
        // Store buffer sizing
        // ----------------------------------------

        localparam int ZAP_STORE_BUFFER_DEPTH = 16;
        localparam int ZAP_SB_IDX_W = $clog2(ZAP_STORE_BUFFER_DEPTH);

        typedef logic [ZAP_ADDR_W-1:0] zap_addr_t;
        typedef logic [ZAP_DATA_W-1:0] zap_data_t;
        typedef logic [ZAP_SEL_W-1:0]  zap_sel_t;

        // Extra MSB tells full from empty.
        typedef logic [ZAP_SB_IDX_W:0] zap_sb_ptr_t;

        // Owner of the shared bus.
        typedef enum logic [1:0]
        {
                GNT_IDLE,
                GNT_CODE,
                GNT_DATA
        } zap_grant_t;

endpackage

`default_nettype wire

// ==== src/zap_store_buffer.sv ====
// ----------------------------------------
// Store buffer and Wishbone master.
// Posts writes into a FIFO and acks them at
// once, then drains them in order as single
// classic cycles. Reads go out only once the
// FIFO is empty so they see earlier stores.
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module zap_store_buffer
(
        input   logic                   i_clk,
        input   logic                   i_rst_n,

        // ----------------------------------------
        // Request side
        // ----------------------------------------

        input   logic                   i_stb,
        input   logic                   i_we,
        input   zap_pkg::zap_addr_t     i_adr,
        input   zap_pkg::zap_sel_t      i_sel,
        input   zap_pkg::zap_data_t     i_dat,
        output  logic                   o_ack,
        output  zap_pkg::zap_data_t     o_dat,

        // ----------------------------------------
        // External Wishbone bus
        // ----------------------------------------

        output  logic                   o_wb_cyc,
        output  logic                   o_wb_stb,
        output  logic                   o_wb_we,
        output  zap_pkg::zap_addr_t     o_wb_adr,
        output  zap_pkg::zap_sel_t      o_wb_sel,
        output  zap_pkg::zap_data_t     o_wb_dat,
        input   logic                   i_wb_ack,
        input   zap_pkg::zap_data_t     i_wb_dat
);

// External bus sequencer.
typedef enum logic [1:0]
{
        SB_IDLE,
        SB_WRITE,
        SB_READ
} sb_state_t;

sb_state_t              state_q;
zap_pkg::zap_sb_ptr_t   wr_ptr;
zap_pkg::zap_sb_ptr_t   rd_ptr;

logic [zap_pkg::ZAP_SB_IDX_W-1:0] wr_idx;
logic [zap_pkg::ZAP_SB_IDX_W-1:0] rd_idx;

// FIFO storage.
zap_pkg::zap_addr_t     adr_mem [zap_pkg::ZAP_STORE_BUFFER_DEPTH];
zap_pkg::zap_sel_t      sel_mem [zap_pkg::ZAP_STORE_BUFFER_DEPTH];
zap_pkg::zap_data_t     dat_mem [zap_pkg::ZAP_STORE_BUFFER_DEPTH];

logic empty;
logic full;
logic push;
logic pop;
logic start_wr;
logic start_rd;
logic rd_done;

assign wr_idx = wr_ptr[zap_pkg::ZAP_SB_IDX_W-1:0];
assign rd_idx = rd_ptr[zap_pkg::ZAP_SB_IDX_W-1:0];

assign empty = (wr_ptr == rd_ptr);
assign full  = (wr_idx == rd_idx) &&
               (wr_ptr[zap_pkg::ZAP_SB_IDX_W] != rd_ptr[zap_pkg::ZAP_SB_IDX_W]);

// A pending ack means this write is already in.
assign push = i_stb && i_we && !full && !o_ack;

// Drain has priority; a read needs an empty FIFO and idle bus.
assign start_wr = (state_q == SB_IDLE) && !empty;
assign start_rd = (state_q == SB_IDLE) && empty && i_stb && !i_we && !o_ack;

assign pop     = (state_q == SB_WRITE) && i_wb_ack;    // Head is out.
assign rd_done = (state_q == SB_READ)  && i_wb_ack;

// ----------------------------------------
// Control state
// ----------------------------------------

always_ff @(posedge i_clk or negedge i_rst_n)
begin
        if (!i_rst_n)
        begin
                state_q <= SB_IDLE;
                wr_ptr  <= '0;
                rd_ptr  <= '0;
                o_ack   <= 1'b0;
        end
        else
        begin
                o_ack <= push || rd_done;       // Single cycle pulse.

                if (push)
                        wr_ptr <= wr_ptr + 1'b1;

                if (pop)
                        rd_ptr <= rd_ptr + 1'b1;

                case (state_q)
                SB_IDLE:
                begin
                        if (start_wr)
                                state_q <= SB_WRITE;
                        else if (start_rd)
                                state_q <= SB_READ;
                end

                SB_WRITE, SB_READ:
                begin
                        if (i_wb_ack)
                                state_q <= SB_IDLE;     // One transfer at a time.
                end

                default:
                begin
                        state_q <= SB_IDLE;
                end
                endcase
        end
end

// ----------------------------------------
// Payload path
// ----------------------------------------

always_ff @(posedge i_clk)
begin
        if (push)
        begin
                adr_mem[wr_idx] <= i_adr;
                sel_mem[wr_idx] <= i_sel;
                dat_mem[wr_idx] <= i_dat;
        end

        if (start_wr)
        begin
                o_wb_adr <= adr_mem[rd_idx];    // Present the head.
                o_wb_sel <= sel_mem[rd_idx];
                o_wb_dat <= dat_mem[rd_idx];
        end
        else if (start_rd)
        begin
                o_wb_adr <= i_adr;
                o_wb_sel <= i_sel;
        end

        if (rd_done)
                o_dat <= i_wb_dat;              // Returned read word.
end

// Strobes held from start until ack.
assign o_wb_cyc = (state_q != SB_IDLE);
assign o_wb_stb = (state_q != SB_IDLE);
assign o_wb_we  = (state_q == SB_WRITE);

endmodule

`default_nettype wire

// ==== src/zap_wb_merger.sv ====
// ----------------------------------------
// Code/data bus merger.
// Arbitrates the instruction fetch port and
// the data port onto one shared request bus.
// Data wins a tie. The grant is held until
// the granted port is acked.
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module zap_wb_merger
(
        input   logic                   i_clk,
        input   logic                   i_rst_n,

        // ----------------------------------------
        // Code port
        // ----------------------------------------

        input   logic                   i_c_stb,
        input   zap_pkg::zap_addr_t     i_c_adr,
        output  logic                   o_c_ack,

        // ----------------------------------------
        // Data port
        // ----------------------------------------

        input   logic                   i_d_stb,
        input   logic                   i_d_we,
        input   zap_pkg::zap_addr_t     i_d_adr,
        input   zap_pkg::zap_sel_t      i_d_sel,
        input   zap_pkg::zap_data_t     i_d_dat,
        output  logic                   o_d_ack,

        // ----------------------------------------
        // Shared side
        // ----------------------------------------

        output  logic                   o_stb,
        output  logic                   o_we,
        output  zap_pkg::zap_addr_t     o_adr,
        output  zap_pkg::zap_sel_t      o_sel,
        output  zap_pkg::zap_data_t     o_dat,
        input   logic                   i_ack
);

zap_pkg::zap_grant_t grant_q;
zap_pkg::zap_grant_t grant_nxt;

// Next grant.
always_comb
begin
        grant_nxt = grant_q;

        case (grant_q)
        zap_pkg::GNT_IDLE:
        begin
                if (i_d_stb)
                        grant_nxt = zap_pkg::GNT_DATA;  // Data first.
                else if (i_c_stb)
                        grant_nxt = zap_pkg::GNT_CODE;
        end

        zap_pkg::GNT_CODE, zap_pkg::GNT_DATA:
        begin
                if (i_ack)
                        grant_nxt = zap_pkg::GNT_IDLE;  // Release after ack.
        end

        default:
        begin
                grant_nxt = zap_pkg::GNT_IDLE;
        end
        endcase
end

always_ff @(posedge i_clk or negedge i_rst_n)
begin
        if (!i_rst_n)
                grant_q <= zap_pkg::GNT_IDLE;
        else
                grant_q <= grant_nxt;
end

// ----------------------------------------
// Request mux
// ----------------------------------------

always_comb
begin
        o_stb = 1'b0;
        o_we  = 1'b0;
        o_adr = i_d_adr;
        o_sel = i_d_sel;
        o_dat = i_d_dat;

        case (grant_q)
        zap_pkg::GNT_CODE:
        begin
                // Fetches are whole aligned words.
                o_stb = i_c_stb;
                o_adr = {i_c_adr[zap_pkg::ZAP_ADDR_W-1:2], 2'b00};
                o_sel = '1;
                o_dat = '0;
        end

        zap_pkg::GNT_DATA:
        begin
                o_stb = i_d_stb;
                o_we  = i_d_we;
        end

        default:
        begin
                o_stb = 1'b0;   // Nobody owns the bus.
        end
        endcase
end

// Ack goes back only to the owner.
assign o_c_ack = (grant_q == zap_pkg::GNT_CODE) && i_ack;
assign o_d_ack = (grant_q == zap_pkg::GNT_DATA) && i_ack;

endmodule

`default_nettype wire

// ==== verification/tb_clk_gen.sv ====
// ----------------------------------------
// Testbench clock source.
// Free running 10 ns clock.
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen
(
        output  logic   o_clk
);

initial
begin
        o_clk = 1'b0;
        forever
                #5 o_clk = ~o_clk;      // Half of a 10 ns period.
end

endmodule

`default_nettype wire

// ==== verification/tb_zap_mem_top.sv ====
// ----------------------------------------
// Testbench for the memory front end.
// Directed tests drive the fetch and data
// ports against a Wishbone memory model
// with random ack delay and a stall flag.
// ----------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_zap_mem_top;

logic                   clk;
logic                   rst_n;
logic                   irq_in;
logic                   fiq_in;
logic                   irq_out;
logic                   fiq_out;
logic                   instr_stb;
zap_pkg::zap_addr_t     instr_adr;
logic                   instr_ack;
zap_pkg::zap_data_t     instr_dat;
logic                   data_stb;
logic                   data_we;
zap_pkg::zap_addr_t     data_adr;
zap_pkg::zap_sel_t      data_sel;
zap_pkg::zap_data_t     data_wdat;
logic                   data_ack;
zap_pkg::zap_data_t     data_rdat;
logic                   wb_cyc;
logic                   wb_stb;
logic                   wb_we;
zap_pkg::zap_addr_t     wb_adr;
zap_pkg::zap_sel_t      wb_sel;
zap_pkg::zap_data_t     wb_wdat;
logic                   wb_ack;
zap_pkg::zap_data_t     wb_rdat;

// Memory model state and transfer log.
zap_pkg::zap_data_t     slave_mem [zap_pkg::zap_addr_t];
zap_pkg::zap_data_t     ref_mem [zap_pkg::zap_addr_t];     // Expected contents.
zap_pkg::zap_addr_t     log_adr [$];
zap_pkg::zap_sel_t      log_sel [$];
zap_pkg::zap_data_t     log_dat [$];
zap_pkg::zap_addr_t     exp_adr [$];                    // Writes acked to the port.
zap_pkg::zap_sel_t      exp_sel [$];
zap_pkg::zap_data_t     exp_dat [$];
int                     compared;
logic                   stall;                          // Holds the slave ack low.
zap_pkg::zap_addr_t     last_adr;
zap_pkg::zap_sel_t      last_sel;
logic                   last_we;
time                    data_ack_t;
time                    code_ack_t;

tb_clk_gen u_clk_gen
(
        .o_clk          (clk)
);

zap_mem_top dut
(
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_irq          (irq_in),
        .i_fiq          (fiq_in),
        .o_irq          (irq_out),
        .o_fiq          (fiq_out),
        .i_instr_stb    (instr_stb),
        .i_instr_adr    (instr_adr),
        .o_instr_ack    (instr_ack),
        .o_instr_dat    (instr_dat),
        .i_data_stb     (data_stb),
        .i_data_we      (data_we),
        .i_data_adr     (data_adr),
        .i_data_sel     (data_sel),
        .i_data_dat     (data_wdat),
        .o_data_ack     (data_ack),
        .o_data_dat     (data_rdat),
        .o_wb_cyc       (wb_cyc),
        .o_wb_stb       (wb_stb),
        .o_wb_we        (wb_we),
        .o_wb_adr       (wb_adr),
        .o_wb_sel       (wb_sel),
        .o_wb_dat       (wb_wdat),
        .i_wb_ack       (wb_ack),
        .i_wb_dat       (wb_rdat)
);

// ----------------------------------------
// Memory helpers
// ----------------------------------------

function automatic zap_pkg::zap_data_t fill_word(input zap_pkg::zap_addr_t a);
        return {a[15:0], a[31:16]} ^ 32'hb7e1_5163;     // Every address bit counts.
endfunction

function automatic zap_pkg::zap_data_t merge_lanes(input zap_pkg::zap_data_t old_w,
                                                   input zap_pkg::zap_data_t new_w,
                                                   input zap_pkg::zap_sel_t sel);
        zap_pkg::zap_data_t w;
        w = old_w;
        for (int i = 0; i < zap_pkg::ZAP_SEL_W; i++)
                if (sel[i])
                        w[8*i +: 8] = new_w[8*i +: 8];
        return w;
endfunction

function automatic zap_pkg::zap_data_t slave_word(input zap_pkg::zap_addr_t a);
        return slave_mem.exists(a) ? slave_mem[a] : fill_word(a);
endfunction

function automatic zap_pkg::zap_data_t ref_word(input zap_pkg::zap_addr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
endfunction

task automatic check_equal(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual)
        begin
                $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
                $display("*** TEST FAILED ***");
                $fatal(1, "Stopping at the first mismatch.");
        end
endtask

// ----------------------------------------
// Port drivers
// ----------------------------------------

task automatic data_access(input logic we, input zap_pkg::zap_addr_t adr,
                           input zap_pkg::zap_sel_t sel, input zap_pkg::zap_data_t wdat,
                           output zap_pkg::zap_data_t rdat, output int cycles);
        @(negedge clk);
        data_stb  = 1'b1;
        data_we   = we;
        data_adr  = adr;
        data_sel  = sel;
        data_wdat = wdat;
        cycles    = 0;
        do
        begin
                @(negedge clk);
                cycles++;
        end
        while (!data_ack);
        rdat       = data_rdat;
        data_ack_t = $time;
        if (we)
        begin
                exp_adr.push_back(adr);
                exp_sel.push_back(sel);
                exp_dat.push_back(wdat);
                ref_mem[adr] = merge_lanes(ref_word(adr), wdat, sel);
        end
        data_stb = 1'b0;                // Released in the ack cycle.
        data_we  = 1'b0;
endtask

task automatic write_word(input zap_pkg::zap_addr_t adr, input zap_pkg::zap_sel_t sel,
                          input zap_pkg::zap_data_t wdat, output int cycles);
        zap_pkg::zap_data_t unused_rdat;
        data_access(1'b1, adr, sel, wdat, unused_rdat, cycles);
endtask

task automatic fetch_word(input zap_pkg::zap_addr_t adr, output zap_pkg::zap_data_t rdat);
        @(negedge clk);
        instr_stb = 1'b1;
        instr_adr = adr;
        do
        begin
                @(negedge clk);
        end
        while (!instr_ack);
        rdat       = instr_dat;
        code_ack_t = $time;
        instr_stb  = 1'b0;
endtask

// Waits for the bus log to catch up, then compares the new entries.
task automatic drain_and_compare(input string name);
        while (log_adr.size() < exp_adr.size())
                @(negedge clk);
        check_equal({name, " log size"}, exp_adr.size(), log_adr.size());
        for (int i = compared; i < exp_adr.size(); i++)
        begin
                check_equal({name, " adr"}, exp_adr[i], log_adr[i]);
                check_equal({name, " sel"}, 32'(exp_sel[i]), 32'(log_sel[i]));
                check_equal({name, " dat"}, exp_dat[i], log_dat[i]);
        end
        compared = exp_adr.size();
endtask

// ----------------------------------------
// Directed tests
// ----------------------------------------

task automatic reset_and_irq();
        check_equal("reset wb_cyc", 0, 32'(wb_cyc));
        check_equal("reset wb_stb", 0, 32'(wb_stb));
        check_equal("reset instr ack", 0, 32'(instr_ack));
        check_equal("reset data ack", 0, 32'(data_ack));
        check_equal("reset irq", 0, 32'(irq_out));
        check_equal("reset fiq", 0, 32'(fiq_out));
        irq_in = 1'b1;
        @(negedge clk);
        check_equal("irq after one edge", 0, 32'(irq_out));
        @(negedge clk);
        check_equal("irq after two edges", 1, 32'(irq_out));
        fiq_in = 1'b1;
        @(negedge clk);
        check_equal("fiq after one edge", 0, 32'(fiq_out));
        @(negedge clk);
        check_equal("fiq after two edges", 1, 32'(fiq_out));
        irq_in = 1'b0;
        fiq_in = 1'b0;
endtask

task automatic fetch_unaligned();
        zap_pkg::zap_data_t rdat;
        fetch_word(32'h0000_1236, rdat);
        check_equal("fetch bus adr", 32'h0000_1234, last_adr);
        check_equal("fetch bus sel", 32'hf, 32'(last_sel));
        check_equal("fetch bus we", 0, 32'(last_we));
        check_equal("fetch data", ref_word(32'h0000_1234), rdat);
endtask

task automatic posted_writes();
        int cycles;
        stall = 1'b1;                   // Acks must not wait for the slave.
        write_word(32'h100, 4'hf, 32'hdead_0001, cycles);
        check_equal("posted ack 1", 2, cycles);
        write_word(32'h104, 4'h3, 32'h1234_5678, cycles);
        check_equal("posted ack 2", 2, cycles);
        write_word(32'h108, 4'hc, 32'h9abc_def0, cycles);
        check_equal("posted ack 3", 2, cycles);
        write_word(32'h100, 4'h1, 32'h0000_00a5, cycles);
        check_equal("posted ack 4", 2, cycles);
        stall = 1'b0;
        drain_and_compare("posted writes");
endtask

task automatic read_after_writes();
        int cycles;
        zap_pkg::zap_data_t rdat;
        write_word(32'h200, 4'hf, 32'h1111_2222, cycles);
        write_word(32'h204, 4'hf, 32'h3333_4444, cycles);
        write_word(32'h200, 4'hf, 32'h5555_6666, cycles);
        write_word(32'h200, 4'h2, 32'h0000_ab00, cycles);
        data_access(1'b0, 32'h200, 4'hf, '0, rdat, cycles);
        check_equal("read after writes", ref_word(32'h200), rdat);
        drain_and_compare("read after writes");
endtask

task automatic port_contention();
        int cycles;
        zap_pkg::zap_data_t d_rdat;
        zap_pkg::zap_data_t c_rdat;
        fork
                data_access(1'b0, 32'h104, 4'hf, '0, d_rdat, cycles);
                fetch_word(32'h0000_2001, c_rdat);
        join
        check_equal("contention data first", 1, 32'(data_ack_t < code_ack_t));
        check_equal("contention data word", ref_word(32'h104), d_rdat);
        check_equal("contention code word", ref_word(32'h0000_2000), c_rdat);
endtask

task automatic back_pressure();
        int cycles;
        time release_t;
        stall = 1'b1;
        for (int i = 0; i < zap_pkg::ZAP_STORE_BUFFER_DEPTH; i++)
        begin
                write_word(32'h400 + 32'(i * 4), 4'hf, 32'hc0de_0000 + 32'(i), cycles);
                check_equal("back pressure fill ack", 2, cycles);
        end
        fork
                write_word(32'h480, 4'hf, 32'hfeed_beef, cycles);     // Buffer is full.
                begin
                        repeat (20) @(negedge clk);
                        release_t = $time;
                        stall = 1'b0;
                end
        join
        check_equal("back pressure held ack", 1, 32'(data_ack_t > release_t));
        drain_and_compare("back pressure");
endtask

// ----------------------------------------
// Wishbone slave model
// ----------------------------------------

initial
begin : wb_slave
        int   delay;
        logic busy;
        void'($urandom(32'hb158_6fe7));                 // Ack delay sequence.
        wb_ack  = 1'b0;
        wb_rdat = '0;
        delay   = 0;
        busy    = 1'b0;
        forever
        begin
                @(negedge clk);
                if (wb_ack)
                        wb_ack = 1'b0;                  // One cycle pulse.
                else if (wb_cyc && wb_stb)
                begin
                        if (!busy)
                        begin
                                busy  = 1'b1;
                                delay = int'($urandom % 4);
                                // Reads only once every posted write is out.
                                if (!wb_we)
                                        check_equal("read waits for drain",
                                                    exp_adr.size(), log_adr.size());
                        end
                        if (delay > 0)
                                delay--;
                        else if (!stall)
                        begin
                                busy     = 1'b0;
                                last_adr = wb_adr;
                                last_sel = wb_sel;
                                last_we  = wb_we;
                                if (wb_we)
                                begin
                                        slave_mem[wb_adr] = merge_lanes(slave_word(wb_adr),
                                                                        wb_wdat, wb_sel);
                                        log_adr.push_back(wb_adr);
                                        log_sel.push_back(wb_sel);
                                        log_dat.push_back(wb_wdat);
                                end
                                else
                                        wb_rdat = slave_word(wb_adr);
                                wb_ack = 1'b1;
                        end
                end
        end
end

// ----------------------------------------
// Main sequence and watchdog
// ----------------------------------------

initial
begin
        rst_n     = 1'b0;
        irq_in    = 1'b0;
        fiq_in    = 1'b0;
        instr_stb = 1'b0;
        instr_adr = '0;
        data_stb  = 1'b0;
        data_we   = 1'b0;
        data_adr  = '0;
        data_sel  = '0;
        data_wdat = '0;
        stall     = 1'b0;
        compared  = 0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        reset_and_irq();
        fetch_unaligned();
        posted_writes();
        read_after_writes();
        port_contention();
        back_pressure();
        $display("*** TEST PASSED ***");
        $finish;
end

// Six tests of at most about 3 us each, with margin.
initial
begin
        #20000;
        $display("*** TEST FAILED ***");
        $fatal(1, "Watchdog expired before all tests finished.");
end

endmodule

`default_nettype wire
